// File: common/procPkg.sv
// ==========================================================================
// Shared definitions for the 16-bit five-stage pipelined processor.
// Holds the sizes, opcode and control encodings, and the structs that
// carry instructions and payloads between the stages and the testbench.
// ==========================================================================
`default_nettype none

package procPkg;

   localparam int DataWidth    = 16;
   localparam int RegAddrWidth = 3;
   localparam int MemAddrWidth = 8;

   typedef logic [DataWidth-1:0]    wordT;
   typedef logic [RegAddrWidth-1:0] regAddrT;
   typedef logic [MemAddrWidth-1:0] memAddrT;

   // Opcode field, bits 15:12 of every instruction
   typedef enum logic [3:0] {
      OpAdd  = 4'd0,
      OpSub  = 4'd1,
      OpAnd  = 4'd2,
      OpXor  = 4'd3,
      OpAddi = 4'd4,
      OpLi   = 4'd5,
      OpLd   = 4'd6,
      OpSt   = 4'd7,
      OpBeqz = 4'd8,
      OpJ    = 4'd9,
      OpHalt = 4'd15
   } opcodeT;

   typedef enum logic [1:0] {AluAdd, AluSub, AluAnd, AluXor} aluOpT;

   typedef enum logic {WbAlu, WbMem} wbSelT;

   // low holds rt in its bottom 3 bits, or the 6-bit immediate
   typedef struct packed {
      opcodeT     opcode;
      regAddrT    rd;
      regAddrT    rs;
      logic [5:0] low;
   } instrT;

   typedef struct packed {
      instrT instr;
      wordT  pcInc;
   } fetchPayloadT;

   typedef struct packed {
      aluOpT   aluOp;
      wbSelT   wbSel;
      wordT    opA;
      wordT    opB;
      wordT    storeData;
      wordT    imm;
      wordT    pcInc;
      regAddrT rd;
      logic    regWrt;
      logic    memWrt;
      logic    memRead;
      logic    isBranch;
      logic    isJump;
      logic    isHalt;
   } decodePayloadT;

   typedef struct packed {
      wordT    aluResult;
      wordT    storeData;
      regAddrT rd;
      wbSelT   wbSel;
      logic    regWrt;
      logic    memWrt;
      logic    memRead;
      logic    isHalt;
   } execPayloadT;

   typedef struct packed {
      regAddrT rd;
      wordT    result;
      logic    regWrt;
      logic    isHalt;
   } wbPayloadT;

   typedef struct packed {
      logic    valid;
      regAddrT addr;
      wordT    data;
   } regWriteT;

   typedef struct packed {
      logic    valid;
      memAddrT addr;
      wordT    data;
   } storeT;

   typedef struct packed {
      logic valid;
      wordT target;
   } redirectT;

   // Contents of the execute to memory register
   typedef struct packed {
      execPayloadT exec;
      redirectT    redirect;
   } xmPayloadT;

endpackage

`default_nettype wire

// File: hw/pipeReg.sv
// ==========================================================================
// Pipeline stage register with a valid bit, a stall hold and a flush.
// One instance sits at each stage boundary; payloadT picks its contents.
// ==========================================================================
`default_nettype none

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    stall,
   input  logic    flush,
   input  logic    validIn,
   input  payloadT dataIn,
   output logic    validOut,
   output payloadT dataOut
);

   // Flush wins over stall and leaves a bubble behind
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         validOut <= 1'b0;
      end else if (!stall) begin
         validOut <= validIn;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         dataOut <= dataIn;
      end
   end

endmodule

`default_nettype wire

// File: hw/fetch/fetch.sv
// ==========================================================================
// Fetch stage: program counter and instruction memory.
// The memory is loaded through the write port while rst is held, and
// fetch stops after a HALT until a redirect or the next reset.
// ==========================================================================
`default_nettype none

module fetch import procPkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         stall,
   input  logic         imemWrEn,
   input  memAddrT      imemAddr,
   input  wordT         imemData,
   input  redirectT     redirect,
   input  logic         haltSeen,
   output fetchPayloadT fetchOut,
   output logic         fetchValid
);

   wordT imem [2**MemAddrWidth];
   wordT pc;
   logic stopped;

   // Load port only writes while the core is held in reset
   always_ff @(posedge clk) begin
      if (rst && imemWrEn) begin
         imem[imemAddr] <= imemData;
      end
   end

   always_comb begin
      fetchOut.instr = imem[pc[MemAddrWidth-1:0]];
      fetchOut.pcInc = pc + 1'b1;
   end

   assign fetchValid = !stopped;

   // Redirect beats the decode stall
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (redirect.valid) begin
         pc <= redirect.target;
      end else if (!stall && !stopped) begin
         pc <= fetchOut.pcInc;
      end
   end

   // A HALT on a path that is later redirected must not keep fetch closed
   always_ff @(posedge clk) begin
      if (rst) begin
         stopped <= 1'b0;
      end else if (haltSeen) begin
         stopped <= 1'b1;
      end else if (redirect.valid) begin
         stopped <= 1'b0;
      end else if (fetchValid && !stall && fetchOut.instr.opcode == OpHalt) begin
         stopped <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/decode/decode.sv
// ==========================================================================
// Decode stage: field decode, register file and hazard stall.
// Stalls while X, M or W still owes a register this instruction reads,
// and latches err on any valid illegal opcode until reset.
// ==========================================================================
`default_nettype none

module decode import procPkg::*; (
   input  logic          clk,
   input  logic          rst,
   input  logic          inValid,
   input  fetchPayloadT  inData,
   input  regWriteT      busyX,
   input  regWriteT      busyM,
   input  regWriteT      wbWrite,
   output logic          stall,
   output decodePayloadT outData,
   output logic          outValid,
   output logic          err
);

   wordT    regs [2**RegAddrWidth];
   instrT   instr;
   wordT    raw;
   regAddrT rt;
   wordT    rsVal, rtVal, rdVal;
   wordT    imm6, imm9, imm12;
   logic    useRs, useRt, useRd;
   logic    illegal;

   assign instr = inData.instr;
   assign raw   = inData.instr;
   assign rt    = instr.low[RegAddrWidth-1:0];

   assign imm6  = {{(DataWidth-6){raw[5]}}, raw[5:0]};
   assign imm9  = {{(DataWidth-9){raw[8]}}, raw[8:0]};
   assign imm12 = {{(DataWidth-12){raw[11]}}, raw[11:0]};

   assign rsVal = regs[instr.rs];
   assign rtVal = regs[rt];
   assign rdVal = regs[instr.rd];

   always_comb begin
      outData           = '0;
      outData.aluOp     = AluAdd;
      outData.wbSel     = WbAlu;
      outData.opA       = rsVal;
      outData.opB       = rtVal;
      outData.storeData = rdVal;
      outData.pcInc     = inData.pcInc;
      outData.rd        = instr.rd;
      useRs             = 1'b0;
      useRt             = 1'b0;
      useRd             = 1'b0;
      illegal           = 1'b0;
      case (instr.opcode)
         OpAdd, OpSub, OpAnd, OpXor: begin
            outData.aluOp  = aluOpT'(instr.opcode[1:0]);
            outData.regWrt = 1'b1;
            useRs          = 1'b1;
            useRt          = 1'b1;
         end
         OpAddi, OpLd, OpSt: begin
            outData.imm     = imm6;
            outData.opB     = imm6;
            outData.regWrt  = instr.opcode != OpSt;
            outData.memRead = instr.opcode == OpLd;
            outData.memWrt  = instr.opcode == OpSt;
            outData.wbSel   = (instr.opcode == OpLd) ? WbMem : WbAlu;
            useRs           = 1'b1;
            useRd           = instr.opcode == OpSt;
         end
         OpLi: begin
            // Computed as 0 + imm9 in the ALU
            outData.imm    = imm9;
            outData.opA    = '0;
            outData.opB    = imm9;
            outData.regWrt = 1'b1;
         end
         OpBeqz: begin
            outData.imm      = imm9;
            outData.isBranch = 1'b1;
            useRd            = 1'b1;
         end
         OpJ: begin
            outData.imm    = imm12;
            outData.isJump = 1'b1;
         end
         OpHalt:  outData.isHalt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   function automatic logic owes(regWriteT b, regAddrT r);
      return b.valid && b.addr == r;
   endfunction

   function automatic logic pending(regAddrT r);
      return owes(busyX, r) || owes(busyM, r) || owes(wbWrite, r);
   endfunction

   assign stall = inValid && ((useRs && pending(instr.rs)) ||
                              (useRt && pending(rt)) ||
                              (useRd && pending(instr.rd)));

   // A stalled instruction leaves a bubble for execute
   assign outValid = inValid && !stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**RegAddrWidth; i++) begin
            regs[i] <= '0;
         end
      end else if (wbWrite.valid) begin
         regs[wbWrite.addr] <= wbWrite.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (inValid && illegal) begin
         err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/execute/execute.sv
// ==========================================================================
// Execute stage: ALU, load/store address and branch resolution.
// Purely combinational; the redirect it forms acts once it reaches the
// memory stage.
// ==========================================================================
`default_nettype none

module execute import procPkg::*; (
   input  decodePayloadT inData,
   input  logic          inValid,
   output execPayloadT   outData,
   output redirectT      redirect
);

   wordT aluResult;
   logic rdIsZero;
   logic taken;

   always_comb begin
      case (inData.aluOp)
         AluAdd:  aluResult = inData.opA + inData.opB;
         AluSub:  aluResult = inData.opA - inData.opB;
         AluAnd:  aluResult = inData.opA & inData.opB;
         default: aluResult = inData.opA ^ inData.opB;
      endcase
   end

   // BEQZ tests rd, which decode passes along as the store data
   assign rdIsZero = inData.storeData == '0;
   assign taken    = inData.isJump || (inData.isBranch && rdIsZero);

   always_comb begin
      redirect.valid  = inValid && taken;
      // Both targets are relative to the incremented PC
      redirect.target = inData.pcInc + inData.imm;
   end

   always_comb begin
      outData.aluResult = aluResult;
      outData.storeData = inData.storeData;
      outData.rd        = inData.rd;
      outData.wbSel     = inData.wbSel;
      outData.regWrt    = inData.regWrt;
      outData.memWrt    = inData.memWrt;
      outData.memRead   = inData.memRead;
      outData.isHalt    = inData.isHalt;
   end

endmodule

`default_nettype wire

// File: hw/memory/memory.sv
// ==========================================================================
// Memory stage: data memory and writeback result select.
// Writes at the clock edge, reads combinationally, and shows every valid
// store on the store port.
// ==========================================================================
`default_nettype none

module memory import procPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        inValid,
   input  execPayloadT inData,
   output wbPayloadT   outData,
   output storeT       store
);

   wordT    dmem [2**MemAddrWidth];
   memAddrT addr;
   wordT    loadData;

   // Word addressed, wraps on the low bits
   assign addr = inData.aluResult[MemAddrWidth-1:0];

   always_comb begin
      store.valid = inValid && inData.memWrt;
      store.addr  = addr;
      store.data  = inData.storeData;
   end

   always_ff @(posedge clk) begin
      if (store.valid && !rst) begin
         dmem[addr] <= store.data;
      end
   end

   assign loadData = inData.memRead ? dmem[addr] : '0;

   always_comb begin
      outData.rd     = inData.rd;
      outData.result = (inData.wbSel == WbMem) ? loadData : inData.aluResult;
      outData.regWrt = inData.regWrt;
      outData.isHalt = inData.isHalt;
   end

endmodule

`default_nettype wire

// File: hw/proc.sv
// ==========================================================================
// Processor top: the four stages joined by the four stage registers.
// Exposes the retire and store ports, halt and err; the instruction
// memory is loaded through imemWrEn/imemAddr/imemData during reset.
// ==========================================================================
`default_nettype none

module proc import procPkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     imemWrEn,
   input  memAddrT  imemAddr,
   input  wordT     imemData,
   output regWriteT retire,
   output storeT    store,
   output logic     halt,
   output logic     err
);

   fetchPayloadT  fOut, dIn;
   decodePayloadT dOut, xIn;
   execPayloadT   xOut;
   xmPayloadT     xmIn, xmOut;
   wbPayloadT     mOut, wOut;
   redirectT      xRedirect, redirect;
   regWriteT      busyX, busyM;
   logic          fValid, dValid, dOutValid, xValid, mValid, wValid;
   logic          decStall;

   // The branch outcome acts from the memory stage
   assign redirect = '{valid: mValid && xmOut.redirect.valid,
                       target: xmOut.redirect.target};

   assign xmIn  = '{exec: xOut, redirect: xRedirect};
   assign busyX = '{valid: xValid && xIn.regWrt, addr: xIn.rd, data: xOut.aluResult};
   assign busyM = '{valid: mValid && xmOut.exec.regWrt, addr: xmOut.exec.rd,
                    data: mOut.result};
   assign retire = '{valid: wValid && wOut.regWrt, addr: wOut.rd, data: wOut.result};
   assign halt   = wValid && wOut.isHalt;

   fetch fetch_i (
      .clk(clk), .rst(rst), .stall(decStall), .imemWrEn(imemWrEn),
      .imemAddr(imemAddr), .imemData(imemData), .redirect(redirect),
      .haltSeen(halt), .fetchOut(fOut), .fetchValid(fValid)
   );

   pipeReg #(.payloadT(fetchPayloadT)) f2d (
      .clk(clk), .rst(rst), .stall(decStall), .flush(redirect.valid),
      .validIn(fValid), .dataIn(fOut), .validOut(dValid), .dataOut(dIn)
   );

   decode decode_i (
      .clk(clk), .rst(rst), .inValid(dValid), .inData(dIn), .busyX(busyX),
      .busyM(busyM), .wbWrite(retire), .stall(decStall), .outData(dOut),
      .outValid(dOutValid), .err(err)
   );

   pipeReg #(.payloadT(decodePayloadT)) d2x (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(redirect.valid),
      .validIn(dOutValid), .dataIn(dOut), .validOut(xValid), .dataOut(xIn)
   );

   execute execute_i (
      .inData(xIn), .inValid(xValid), .outData(xOut), .redirect(xRedirect)
   );

   pipeReg #(.payloadT(xmPayloadT)) x2m (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(redirect.valid),
      .validIn(xValid), .dataIn(xmIn), .validOut(mValid), .dataOut(xmOut)
   );

   memory memory_i (
      .clk(clk), .rst(rst), .inValid(mValid), .inData(xmOut.exec),
      .outData(mOut), .store(store)
   );

   pipeReg #(.payloadT(wbPayloadT)) m2w (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
      .validIn(mValid), .dataIn(mOut), .validOut(wValid), .dataOut(wOut)
   );

endmodule

`default_nettype wire

// File: test/proc_asserts.sv
// ==========================================================================
// Concurrent checks on pipeline control, bound into every proc instance.
// Covers quiet ports after reset, sticky err, and silence after halt.
// ==========================================================================
`default_nettype none

module procAsserts import procPkg::*; (
   input logic     clk,
   input logic     rst,
   input regWriteT retire,
   input storeT    store,
   input logic     halt,
   input logic     err
);

   timeunit 1ns;
   timeprecision 100ps;

   logic halted;

   // Set by halt, cleared only by reset
   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (halt) begin
         halted <= 1'b1;
      end
   end

   quietAfterReset: assert property (@(posedge clk) rst |=> !retire.valid && !store.valid)
      else $error("retire or store valid right after reset");

   errSticky: assert property (@(posedge clk) err && !rst |=> err)
      else $error("err fell without a reset");

   quietAfterHalt: assert property (@(posedge clk) halted |-> !retire.valid && !store.valid)
      else $error("retire or store valid after halt");

endmodule

bind proc procAsserts procAsserts_i (
   .clk(clk), .rst(rst), .retire(retire), .store(store), .halt(halt), .err(err)
);

`default_nettype wire

// File: test/procTb.sv
// ==========================================================================
// Testbench for the pipelined processor. Builds random programs with
// forward branches from a fixed seed, runs each on an ISA model and
// checks the retire port, store port, halt and err against that model.
// ==========================================================================
`default_nettype none

module procTb import procPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NumPrograms    = 12;
   localparam int MinLen         = 16;
   localparam int LenSpread      = 40;
   localparam int CyclesPerInstr = 20;
   localparam int Margin         = 60;
   localparam int PostHaltCycles = 8;

   logic     clk;
   logic     rst;
   logic     imemWrEn;
   memAddrT  imemAddr;
   wordT     imemData;
   regWriteT retire;
   storeT    store;
   logic     halt;
   logic     err;

   logic [31:0] rngState;
   int          cycleCount;
   int          deadline;
   string       testName;

   // ISA model state; data memory keeps its contents across resets
   wordT     prog [$];
   wordT     mReg [8];
   wordT     mMem [256];
   bit       memWritten [256];
   bit       mErr;
   bit       expErr;
   regWriteT expWrites [$];
   storeT    expStores [$];

   proc proc_i (
      .clk(clk), .rst(rst), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
      .imemData(imemData), .retire(retire), .store(store), .halt(halt), .err(err)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] randWord();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   function automatic int randBelow(int n);
      return int'(randWord() % n);
   endfunction

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic checkRegWrite(input string name, input regWriteT exp, input regWriteT act);
      if (act !== exp) begin
         reportFailure($sformatf(
            "Mismatch in %s: expected r%0d <= %h, actual valid=%b r%0d <= %h",
            name, exp.addr, exp.data, act.valid, act.addr, act.data));
      end
   endtask

   task automatic checkStore(input string name, input storeT exp, input storeT act);
      if (act !== exp) begin
         reportFailure($sformatf(
            "Mismatch in %s: expected mem[%h] <= %h, actual valid=%b mem[%h] <= %h",
            name, exp.addr, exp.data, act.valid, act.addr, act.data));
      end
   endtask

   task automatic checkFlags(input string name, input logic expHalt, input logic expErrFlag,
                             input logic actHalt, input logic actErr);
      if ({actHalt, actErr} !== {expHalt, expErrFlag}) begin
         reportFailure($sformatf("Mismatch in %s: expected halt=%b err=%b, actual halt=%b err=%b",
                                 name, expHalt, expErrFlag, actHalt, actErr));
      end
   endtask

   // Instruction encoders
   function automatic wordT regInstr(opcodeT op, int rd, int rs, int low);
      return {op, 3'(rd), 3'(rs), 6'(low)};
   endfunction

   function automatic wordT immInstr(opcodeT op, int rd, int imm9);
      return {op, 3'(rd), 9'(imm9)};
   endfunction

   task automatic writeReg(input regAddrT r, input wordT v);
      mReg[r] = v;
      expWrites.push_back(regWriteT'{valid: 1'b1, addr: r, data: v});
   endtask

   // Executes one instruction on the model and advances pc
   task automatic stepModel(input wordT ins, inout int pc);
      regAddrT rd, rs, rt;
      wordT    imm6, imm9, imm12, addr;
      rd    = ins[11:9];
      rs    = ins[8:6];
      rt    = ins[2:0];
      imm6  = {{10{ins[5]}}, ins[5:0]};
      imm9  = {{7{ins[8]}}, ins[8:0]};
      imm12 = {{4{ins[11]}}, ins[11:0]};
      pc    = pc + 1;
      case (ins[15:12])
         OpAdd:  writeReg(rd, mReg[rs] + mReg[rt]);
         OpSub:  writeReg(rd, mReg[rs] - mReg[rt]);
         OpAnd:  writeReg(rd, mReg[rs] & mReg[rt]);
         OpXor:  writeReg(rd, mReg[rs] ^ mReg[rt]);
         OpAddi: writeReg(rd, mReg[rs] + imm6);
         OpLi:   writeReg(rd, imm9);
         OpLd: begin
            addr = mReg[rs] + imm6;
            writeReg(rd, mMem[addr[7:0]]);
         end
         OpSt: begin
            addr = mReg[rs] + imm6;
            mMem[addr[7:0]] = mReg[rd];
            memWritten[addr[7:0]] = 1'b1;
            expStores.push_back(storeT'{valid: 1'b1, addr: addr[7:0], data: mReg[rd]});
         end
         OpBeqz: begin
            if (mReg[rd] == '0) pc = pc + int'($signed(imm9));
         end
         OpJ:    pc = pc + int'($signed(imm12));
         OpHalt: ;
         default: mErr = 1'b1;
      endcase
   endtask

   // Random legal instruction; branch targets stay between i+1 and the HALT
   function automatic wordT pickInstr(int i, int len);
      int kind, rd, rs, reach;
      kind  = randBelow(16);
      rd    = randBelow(8);
      rs    = randBelow(8);
      reach = len - 1 - i;
      if (kind < 6) return regInstr(opcodeT'(randBelow(4)), rd, rs, randBelow(8));
      if (kind < 8) return regInstr(OpAddi, rd, rs, randBelow(64));
      if (kind < 10) return immInstr(OpLi, rd, randBelow(512));
      if (kind < 11) return regInstr(OpLd, rd, rs, randBelow(64));
      if (kind < 13) return regInstr(OpSt, rd, rs, randBelow(64));
      if (kind < 15) return immInstr(OpBeqz, rd, randBelow(reach));
      return {OpJ, 12'(randBelow(reach))};
   endfunction

   function automatic int findStoredAddr();
      int start, a, n;
      start = randBelow(256);
      for (n = 0; n < 256; n++) begin
         a = (start + n) & 255;
         if (memWritten[a]) return a;
      end
      return -1;
   endfunction

   task automatic placeExecuted(input wordT ins, inout int pc);
      prog.push_back(ins);
      stepModel(ins, pc);
   endtask

   // Generates the program while the model follows the taken path,
   // so loads can be aimed at addresses that already hold data
   task automatic buildProgram(input int len, input bit withIllegal);
      int   pc, i, illegalAt, addr, imm, base;
      bit   illegalLeft;
      wordT ins;
      prog.delete();
      expWrites.delete();
      expStores.delete();
      for (i = 0; i < 8; i++) mReg[i] = '0;
      mErr        = 1'b0;
      pc          = 0;
      illegalLeft = withIllegal;
      illegalAt   = randBelow(4);
      while (prog.size() < len - 1) begin
         i   = prog.size();
         ins = pickInstr(i, len);
         if (i != pc) begin
            // Skipped slot; a HALT here sits on a flushed path
            if (randBelow(8) == 0) ins = {OpHalt, 12'h000};
            prog.push_back(ins);
         end else if (illegalLeft && i >= illegalAt) begin
            illegalLeft = 1'b0;
            placeExecuted({4'(10 + randBelow(5)), 12'(randWord())}, pc);
         end else begin
            if (ins[15:12] == OpLd) begin
               addr = findStoredAddr();
               if (addr >= 0 && i + 2 < len) begin
                  imm       = randBelow(64) - 32;
                  base      = (addr - imm) & 255;
                  ins[5:0]  = 6'(imm);
                  placeExecuted(immInstr(OpLi, ins[8:6], base), pc);
               end else begin
                  ins = immInstr(OpLi, ins[11:9], randBelow(512));
               end
            end
            placeExecuted(ins, pc);
         end
      end
      prog.push_back({OpHalt, 12'h000});
      expErr = mErr;
   endtask

   task automatic nextDriveSlot();
      @(posedge clk);
      #1;
   endtask

   // Called with rst already high; loads imem, then holds reset 2 cycles
   task automatic loadProgram();
      int a;
      for (a = 0; a < prog.size(); a++) begin
         imemWrEn = 1'b1;
         imemAddr = memAddrT'(a);
         imemData = prog[a];
         nextDriveSlot();
      end
      imemWrEn = 1'b0;
      nextDriveSlot();
      nextDriveSlot();
      rst = 1'b0;
   endtask

   task automatic runToHalt();
      do @(negedge clk); while (halt !== 1'b1);
      repeat (PostHaltCycles) begin
         @(negedge clk);
         checkFlags(testName, 1'b0, expErr, halt, err);
      end
   endtask

   // Retire and store monitors, sampled mid-cycle
   always @(negedge clk) begin
      if (!rst) begin
         if (retire.valid) begin
            if (expWrites.size() == 0) begin
               reportFailure($sformatf("%s retired a register write the model does not have",
                                       testName));
            end else begin
               checkRegWrite(testName, expWrites.pop_front(), retire);
            end
         end
         if (store.valid) begin
            if (expStores.size() == 0) begin
               reportFailure($sformatf("%s made a store the model does not have", testName));
            end else begin
               checkStore(testName, expStores.pop_front(), store);
            end
         end
         if (halt) begin
            if (expWrites.size() != 0 || expStores.size() != 0) begin
               reportFailure($sformatf("%s halted with %0d writes and %0d stores still missing",
                                       testName, expWrites.size(), expStores.size()));
            end else begin
               checkFlags(testName, 1'b1, expErr, halt, err);
            end
         end else if (err && !expErr) begin
            reportFailure($sformatf("%s raised err with no illegal opcode", testName));
         end
      end
   end

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount > deadline) begin
         reportFailure($sformatf("Timeout: %s did not halt within its cycle budget", testName));
      end
   end

   initial begin
      int k;
      int len;
      clk        = 1'b0;
      rst        = 1'b1;
      imemWrEn   = 1'b0;
      imemAddr   = '0;
      imemData   = '0;
      rngState   = 32'hee34;
      cycleCount = 0;
      deadline   = 100;
      testName   = "startup";
      expErr     = 1'b0;
      for (k = 0; k < NumPrograms; k++) begin
         nextDriveSlot();
         rst      = 1'b1;
         testName = $sformatf("prog%0d", k);
         len      = MinLen + randBelow(LenSpread);
         buildProgram(len, (k % 4) == 3);
         $display("%s: %0d instructions, %0d writes, %0d stores, illegal=%0b",
                  testName, len, expWrites.size(), expStores.size(), expErr);
         deadline = cycleCount + len + 2 + CyclesPerInstr * len + Margin;
         loadProgram();
         runToHalt();
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
common/procPkg.sv
hw/pipeReg.sv
hw/fetch/fetch.sv
hw/decode/decode.sv
hw/execute/execute.sv
hw/memory/memory.sv
hw/proc.sv
test/proc_asserts.sv
test/procTb.sv

// File: Bender.yml
package:
  name: proc

sources:
  - common/procPkg.sv
  - hw/pipeReg.sv
  - hw/fetch/fetch.sv
  - hw/decode/decode.sv
  - hw/execute/execute.sv
  - hw/memory/memory.sv
  - hw/proc.sv
  - target: test
    files:
      - test/proc_asserts.sv
      - test/procTb.sv
